// File: vlog.f
rtl/openadc_pkg.sv
rtl/adc_regs.sv
rtl/level_trigger.sv
rtl/clock_monitor.sv
rtl/openadc_top.sv
testbench/openadc_checker.sv
testbench/tb_openadc.sv

// File: Bender.yml
package:
  name: openadc

sources:
  - rtl/openadc_pkg.sv
  - rtl/adc_regs.sv
  - rtl/level_trigger.sv
  - rtl/clock_monitor.sv
  - rtl/openadc_top.sv
  - target: simulation
    files:
      - testbench/openadc_checker.sv
      - testbench/tb_openadc.sv

// File: testbench/tb_openadc.sv
`timescale 1ns/1ps

module tb_openadc;

   localparam int op_wr = 0, op_rd = 1, op_rdz = 2, op_wait = 3, op_smp = 4, op_rnd = 5;
   localparam int op_cnt = 6, op_ext = 7, op_fwait = 8, op_flash = 9, op_pwm = 10;
   localparam int op_led = 11, op_end = 12;

   typedef struct {
      int op;
      int addr;   // address, sample, count target or random mode
      int data;   // write data, tolerance or length
      int exp;
   } row_t;

   logic       clk_usb;
   logic       reset;
   logic [7:0] reg_address;
   logic [7:0] reg_datai;
   logic       reg_read;
   logic       reg_write;
   logic [11:0] adc_data;
   logic       adc_valid;
   logic       ext_clk;
   logic [7:0] reg_datao;
   logic       trigger_adc, amp_gain, led_armed, led_capture, freq_measure;
   logic [2:0] chk_sel;
   logic [7:0] chk_exp;
   logic [7:0] chk_tol;
   int         tests_passed, tests_failed;
   int         ext_period = 0;
   int         nstrobe = 0;    // valid strobes since reset
   int         seed = 33;
   int         cycles = 0;
   int         limit = 0;
   row_t       rows[$];

   openadc_top #(.p_window_log2(5)) dut (
      .clk_usb(clk_usb), .reset(reset), .reg_address_i(reg_address),
      .reg_datai_i(reg_datai), .reg_read_i(reg_read), .reg_write_i(reg_write),
      .adc_data_i(adc_data), .adc_valid_i(adc_valid), .ext_clk_i(ext_clk),
      .reg_datao_o(reg_datao), .trigger_adc_o(trigger_adc), .amp_gain_o(amp_gain),
      .led_armed_o(led_armed), .led_capture_o(led_capture), .freq_measure_o(freq_measure)
   );

   openadc_checker u_checker (
      .clk_usb(clk_usb), .reset(reset), .reg_datao_i(reg_datao),
      .trigger_adc_i(trigger_adc), .amp_gain_i(amp_gain), .led_armed_i(led_armed),
      .led_capture_i(led_capture), .freq_measure_i(freq_measure), .chk_sel_i(chk_sel),
      .exp_i(chk_exp), .tol_i(chk_tol), .tests_passed_o(tests_passed),
      .tests_failed_o(tests_failed)
   );

   initial begin
      clk_usb = 1'b0;
      forever #10 clk_usb = ~clk_usb;
   end

   // parks low while the period is 0, period read at the clock edge
   initial begin
      int half_cnt;
      ext_clk  = 1'b0;
      half_cnt = 0;
      forever begin
         @(posedge clk_usb);
         if (ext_period == 0) begin
            half_cnt = 0;
            #2 ext_clk = 1'b0;
         end else begin
            half_cnt++;
            if (half_cnt >= ext_period / 2) begin
               half_cnt = 0;
               #2 ext_clk = ~ext_clk;
            end
         end
      end
   end

   initial begin
      wait (limit > 0);
      while (cycles <= limit) begin
         @(posedge clk_usb);
         cycles++;
      end
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("*** FAILED ***");
      $finish;
   end

   task automatic add_row(input int op, input int addr, input int data, input int exp);
      row_t r;
      r = '{op, addr, data, exp};
      rows.push_back(r);
   endtask

   // next cycle, 2 ns after the edge, with idle defaults
   task automatic tick();
      @(posedge clk_usb);
      #2;
      reg_write = 1'b0;
      reg_read  = 1'b0;
      adc_valid = 1'b0;
      chk_sel   = 3'd0;
   endtask

   task automatic post(input int sel, input int exp, input int tol);
      chk_sel = sel;
      chk_exp = exp;
      chk_tol = tol;
   endtask

   task automatic drive_sample(input int val, input int fire);
      tick();
      adc_valid = 1'b1;
      adc_data  = val;
      nstrobe++;
      post(2, 0, 0);
      tick();
      post(2, 0, 0);
      tick();
      post(2, fire, 0);   // two cycles after the valid cycle
      tick();
      post(2, 0, 0);
   endtask

   function automatic int row_cycles(input row_t r);
      case (r.op)
         op_wait, op_flash: return r.data;
         op_smp:            return 4;
         op_rnd:            return 4 * r.data;
         op_cnt:            return r.addr + 8;
         op_fwait:          return 64 * r.data + 64;
         op_pwm:            return 260;
         default:           return 1;
      endcase
   endfunction

   task automatic apply_row(input row_t r);
      int val;
      case (r.op)
         op_wr: begin
            tick();
            reg_write   = 1'b1;
            reg_address = r.addr;
            reg_datai   = r.data;
         end
         op_rd, op_rdz: begin
            tick();
            reg_read    = (r.op == op_rd);
            reg_address = r.addr;
            post(1, r.exp, r.data);
         end
         op_wait: repeat (r.data) tick();
         op_smp:  drive_sample(r.addr, r.exp);
         op_rnd: begin
            repeat (r.data) begin
               val = $random(seed);
               if (r.addr == 1)
                  val = val & 'h7ff;           // stays below 0x900
               else
                  val = (val & 'h3ff) | 'h400; // stays above 0x100
               drive_sample(val, 0);
            end
         end
         op_cnt: begin
            while (((nstrobe + 1) & 'hfff) != r.addr + 1) begin
               tick();
               adc_valid = 1'b1;
               nstrobe++;
               post(2, 0, 0);
            end
            drive_sample(0, 1);
         end
         op_ext: ext_period = r.data;
         op_fwait: begin
            val = 0;
            while (val < r.data) begin
               tick();
               if (freq_measure)
                  val++;
            end
         end
         op_flash: begin
            repeat (r.data) begin
               tick();
               post(4, 0, 0);
            end
         end
         op_pwm: begin
            tick();
            post(5, r.exp, 0);
            repeat (258) tick();
         end
         op_led: begin
            tick();
            post(3, r.exp, 0);
         end
         op_end: begin
            tick();
            post(6, r.addr, 0);
         end
         default: ;
      endcase
   endtask

   initial begin
      int total;
      reset = 1'b1;
      reg_address = '0;
      reg_datai = '0;
      reg_read = 1'b0;
      reg_write = 1'b0;
      adc_data = '0;
      adc_valid = 1'b0;
      chk_sel = '0;
      chk_exp = '0;
      chk_tol = '0;

      // register readback
      add_row(op_wr, 'h01, 'h5a, 0);
      add_row(op_wr, 'h02, 'hc3, 0);
      add_row(op_wr, 'h03, 'hf7, 0);
      add_row(op_wr, 'h08, 'h34, 0);
      add_row(op_wr, 'h09, 'h12, 0);
      add_row(op_wr, 'h00, 'h1f, 0);
      add_row(op_rd, 'h01, 0, 'h5a);
      add_row(op_rd, 'h02, 0, 'hc3);
      add_row(op_rd, 'h03, 0, 'h07);
      add_row(op_rd, 'h08, 0, 'h34);
      add_row(op_rd, 'h09, 0, 'h12);
      add_row(op_rd, 'h00, 0, 'h1e);
      add_row(op_rd, 'h0c, 0, 'h01);
      add_row(op_rd, 'h04, 0, 'h00);
      add_row(op_rdz, 'h01, 0, 'h00);
      add_row(op_end, 1, 0, 0);
      // pwm gain
      add_row(op_wr, 'h01, 0, 0);
      add_row(op_pwm, 0, 0, 0);
      add_row(op_wr, 'h01, 1, 0);
      add_row(op_pwm, 0, 0, 1);
      add_row(op_wr, 'h01, 128, 0);
      add_row(op_pwm, 0, 0, 128);
      add_row(op_wr, 'h01, 200, 0);
      add_row(op_pwm, 0, 0, 200);
      add_row(op_end, 2, 0, 0);
      // level trigger, adc source, above then below
      add_row(op_wr, 'h02, 'h00, 0);
      add_row(op_wr, 'h03, 'h09, 0);
      add_row(op_wr, 'h00, 'h03, 0);
      add_row(op_wait, 0, 2, 0);
      add_row(op_rnd, 1, 8, 0);
      add_row(op_smp, 'ha00, 0, 1);
      add_row(op_smp, 'hb00, 0, 0);
      add_row(op_rd, 'h0c, 0, 'h00);
      add_row(op_wr, 'h03, 'h01, 0);
      add_row(op_wr, 'h00, 'h03, 0);
      add_row(op_wait, 0, 2, 0);
      add_row(op_rnd, 0, 8, 0);
      add_row(op_smp, 'h050, 0, 1);
      add_row(op_smp, 'h020, 0, 0);
      add_row(op_end, 3, 0, 0);
      // level trigger, counter source
      add_row(op_wr, 'h02, 'h05, 0);
      add_row(op_wr, 'h03, 'h08, 0);
      add_row(op_wr, 'h00, 'h01, 0);
      add_row(op_wait, 0, 2, 0);
      add_row(op_cnt, 'h805, 0, 0);
      add_row(op_rd, 'h0c, 0, 'h00);
      add_row(op_end, 4, 0, 0);
      // frequency, 64 / 4 edges per window
      add_row(op_ext, 0, 4, 0);
      add_row(op_fwait, 0, 2, 0);
      add_row(op_rd, 'h04, 1, 'h10);
      add_row(op_rd, 'h05, 0, 'h00);
      add_row(op_end, 5, 0, 0);
      // clock change, flash, disable, status led
      add_row(op_wr, 'h08, 'h02, 0);
      add_row(op_wr, 'h09, 'h00, 0);
      add_row(op_ext, 0, 8, 0);
      add_row(op_fwait, 0, 3, 0);
      add_row(op_flash, 0, 200, 0);
      add_row(op_ext, 0, 0, 0);
      add_row(op_wait, 0, 5, 0);
      add_row(op_rd, 'h0c, 0, 'h02);
      add_row(op_wr, 'h00, 'h12, 0);
      add_row(op_wait, 0, 2, 0);
      add_row(op_rd, 'h0c, 0, 'h00);
      add_row(op_wr, 'h00, 'h13, 0);
      add_row(op_wait, 0, 2, 0);
      add_row(op_led, 0, 0, 1);
      add_row(op_rd, 'h0c, 0, 'h01);
      add_row(op_smp, 'hfff, 0, 1);
      add_row(op_led, 0, 0, 0);
      add_row(op_end, 6, 0, 0);

      total = 16;
      foreach (rows[i])
         total += row_cycles(rows[i]);
      limit = total + total / 2;

      repeat (16) @(posedge clk_usb);
      #2 reset = 1'b0;
      foreach (rows[i])
         apply_row(rows[i]);
      tick();
      tick();

      $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && tests_passed > 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: testbench/openadc_checker.sv
`timescale 1ns/1ps

module openadc_checker (
   input  logic       clk_usb,
   input  logic       reset,
   input  logic [7:0] reg_datao_i,
   input  logic       trigger_adc_i,
   input  logic       amp_gain_i,
   input  logic       led_armed_i,
   input  logic       led_capture_i,
   input  logic       freq_measure_i,
   input  logic [2:0] chk_sel_i,   // 1 read, 2 trigger, 3 led, 4 flash, 5 pwm, 6 test end
   input  logic [7:0] exp_i,
   input  logic [7:0] tol_i,
   output int         tests_passed_o,
   output int         tests_failed_o
);
   int         test_errs = 0;
   int         pwm_left = 0;
   int         pwm_cnt;
   int         diff;
   int         fm_gap = 0;      // cycles since the last window pulse
   logic       fm_seen = 1'b0;
   logic [7:0] pwm_exp;
   logic [7:0] timer_q;   // low byte of the dut window timer
   logic       flash;

   initial begin
      tests_passed_o = 0;
      tests_failed_o = 0;
   end

   task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act) begin
         $display("FAILED %s expected %h got %h", name, exp, act);
         test_errs++;
      end
   endtask

   always @(posedge clk_usb) begin
      flash = ~timer_q[7];   // timer bit 7 with 64 cycle windows
      timer_q = reset ? 8'd0 : timer_q + 8'd1;

      // one window pulse every 64 cycles, one cycle wide
      if (reset) begin
         fm_gap  = 0;
         fm_seen = 1'b0;
      end else begin
         fm_gap++;
         if (freq_measure_i) begin
            if (fm_seen)
               check_value("freq_measure_o period", 16'd64, fm_gap);
            fm_seen = 1'b1;
            fm_gap  = 0;
         end
      end

      if (pwm_left > 0) begin
         pwm_cnt += amp_gain_i;
         pwm_left--;
         if (pwm_left == 0)
            check_value("amp_gain_o high count", pwm_exp, pwm_cnt);
      end

      case (chk_sel_i)
         3'd1: begin
            diff = int'(reg_datao_i) - int'(exp_i);
            if (diff < 0)
               diff = -diff;
            if ($isunknown(reg_datao_i) || diff > tol_i) begin
               $display("FAILED reg_datao_o expected %h got %h", exp_i, reg_datao_i);
               test_errs++;
            end
         end
         3'd2: check_value("trigger_adc_o", exp_i[0], trigger_adc_i);
         3'd3: check_value("led_armed_o", exp_i[0], led_armed_i);
         3'd4: begin
            check_value("led_armed_o", flash, led_armed_i);
            check_value("led_capture_o", flash, led_capture_i);
         end
         3'd5: begin
            pwm_left = 256;
            pwm_cnt  = 0;
            pwm_exp  = exp_i;
         end
         3'd6: begin
            if (test_errs == 0) begin
               $display("test %0d finished ok", exp_i);
               tests_passed_o++;
            end else begin
               $display("test %0d finished with %0d errors", exp_i, test_errs);
               tests_failed_o++;
            end
            test_errs = 0;
         end
         default: ;
      endcase
   end

endmodule

// File: rtl/openadc_top.sv
`timescale 1ns/1ps

module openadc_top #(
   parameter int p_window_log2 = 23
) (
   input  logic                                   clk_usb,
   input  logic                                   reset,
   input  logic [openadc_pkg::reg_addr_width-1:0] reg_address_i,
   input  logic [openadc_pkg::reg_data_width-1:0] reg_datai_i,
   input  logic                                   reg_read_i,
   input  logic                                   reg_write_i,
   input  logic [openadc_pkg::adc_width-1:0]      adc_data_i,
   input  logic                                   adc_valid_i,
   input  logic                                   ext_clk_i,
   output logic [openadc_pkg::reg_data_width-1:0] reg_datao_o,
   output logic                                   trigger_adc_o,
   output logic                                   amp_gain_o,
   output logic                                   led_armed_o,
   output logic                                   led_capture_o,
   output logic                                   freq_measure_o
);
   import openadc_pkg::*;

   logic                   data_source;
   logic                   arm_pulse;
   adc_level_u             trigger_level;
   led_sel_t               led_select;
   logic                   monitor_disable;
   logic [limit_width-1:0] ext_limit;
   logic                   armed;
   logic [freq_width-1:0]  ext_freq;
   logic                   ext_changed;
   logic                   ext_clk_level;

   adc_regs u_adc_regs (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .reg_address_i     (reg_address_i),
      .reg_datai_i       (reg_datai_i),
      .reg_read_i        (reg_read_i),
      .reg_write_i       (reg_write_i),
      .armed_i           (armed),
      .ext_freq_i        (ext_freq),
      .ext_changed_i     (ext_changed),
      .ext_clk_level_i   (ext_clk_level),
      .reg_datao_o       (reg_datao_o),
      .arm_pulse_o       (arm_pulse),
      .data_source_o     (data_source),
      .trigger_level_o   (trigger_level),
      .led_select_o      (led_select),
      .monitor_disable_o (monitor_disable),
      .ext_limit_o       (ext_limit),
      .amp_gain_o        (amp_gain_o)
   );

   level_trigger u_level_trigger (
      .clk_usb         (clk_usb),
      .reset           (reset),
      .adc_data_i      (adc_data_i),
      .adc_valid_i     (adc_valid_i),
      .data_source_i   (data_source),
      .arm_pulse_i     (arm_pulse),
      .trigger_level_i (trigger_level),
      .trigger_adc_o   (trigger_adc_o),
      .armed_o         (armed)
   );

   clock_monitor #(
      .p_window_log2 (p_window_log2)
   ) u_clock_monitor (
      .clk_usb           (clk_usb),
      .reset             (reset),
      .ext_clk_i         (ext_clk_i),
      .armed_i           (armed),
      .led_select_i      (led_select),
      .monitor_disable_i (monitor_disable),
      .ext_limit_i       (ext_limit),
      .freq_measure_o    (freq_measure_o),
      .ext_freq_o        (ext_freq),
      .ext_changed_o     (ext_changed),
      .ext_clk_level_o   (ext_clk_level),
      .led_armed_o       (led_armed_o),
      .led_capture_o     (led_capture_o)
   );

endmodule

// File: rtl/clock_monitor.sv
`timescale 1ns/1ps

module clock_monitor #(
   parameter int p_window_log2 = 23
) (
   input  logic                                clk_usb,
   input  logic                                reset,
   input  logic                                ext_clk_i,
   input  logic                                armed_i,
   input  openadc_pkg::led_sel_t               led_select_i,
   input  logic                                monitor_disable_i,
   input  logic [openadc_pkg::limit_width-1:0] ext_limit_i,
   output logic                                freq_measure_o,
   output logic [openadc_pkg::freq_width-1:0]  ext_freq_o,
   output logic                                ext_changed_o,
   output logic                                ext_clk_level_o,
   output logic                                led_armed_o,
   output logic                                led_capture_o
);
   import openadc_pkg::*;

   localparam int timer_width = p_window_log2 + 3;

   logic [timer_width-1:0] timer;
   logic                   window_bit_q;
   logic                   window_end;
   logic                   ext_meta;
   logic                   ext_sync;
   logic                   ext_sync_q;
   logic                   ext_rise;
   logic [freq_width-1:0]  edge_cnt;
   logic [freq_width-1:0]  freq_diff;
   logic [freq_width-1:0]  limit_wide;
   logic                   flash_pattern;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         timer          <= '0;
         window_bit_q   <= 1'b0;
         freq_measure_o <= 1'b0;
      end else begin
         timer          <= timer + 1'b1;
         window_bit_q   <= timer[p_window_log2];
         freq_measure_o <= window_end;
      end
   end

   assign window_end = timer[p_window_log2] && !window_bit_q;

   // two flop sync plus one for edge detect
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ext_meta   <= 1'b0;
         ext_sync   <= 1'b0;
         ext_sync_q <= 1'b0;
      end else begin
         ext_meta   <= ext_clk_i;
         ext_sync   <= ext_meta;
         ext_sync_q <= ext_sync;
      end
   end

   assign ext_rise        = ext_sync && !ext_sync_q;
   assign ext_clk_level_o = ext_sync;

   assign freq_diff  = (ext_freq_o > edge_cnt) ? ext_freq_o - edge_cnt : edge_cnt - ext_freq_o;
   assign limit_wide = {{(freq_width - limit_width){1'b0}}, ext_limit_i};

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         edge_cnt      <= '0;
         ext_freq_o    <= '0;
         ext_changed_o <= 1'b0;
      end else begin
         if (window_end) begin
            ext_freq_o <= edge_cnt;
            edge_cnt   <= {{(freq_width - 1){1'b0}}, ext_rise}; // edge on the boundary counts here
         end else if (ext_rise) begin
            edge_cnt <= edge_cnt + 1'b1;
         end

         if (monitor_disable_i)
            ext_changed_o <= 1'b0;
         else if (window_end && (ext_freq_o != '0) && (freq_diff > limit_wide))
            ext_changed_o <= 1'b1; // sticky
      end
   end

   assign flash_pattern = ~timer[p_window_log2 + 2];

   always_comb begin
      if (ext_changed_o) begin
         led_armed_o   = flash_pattern;
         led_capture_o = flash_pattern;
      end else begin
         case (led_select_i)
            led_status: begin
               led_armed_o   = armed_i;
               led_capture_o = ext_changed_o;
            end
            led_heartbeat: begin
               led_armed_o   = timer[p_window_log2 + 1];
               led_capture_o = edge_cnt[2];
            end
            default: begin
               led_armed_o   = 1'b0;
               led_capture_o = 1'b0;
            end
         endcase
      end
   end

   a_disable_clears: assert property (
      @(posedge clk_usb) disable iff (reset)
      monitor_disable_i |=> !ext_changed_o
   ) else $error("clock change flag set while monitor disabled");

endmodule

// File: rtl/level_trigger.sv
`timescale 1ns/1ps

module level_trigger (
   input  logic                              clk_usb,
   input  logic                              reset,
   input  logic [openadc_pkg::adc_width-1:0] adc_data_i,
   input  logic                              adc_valid_i,
   input  logic                              data_source_i,
   input  logic                              arm_pulse_i,
   input  openadc_pkg::adc_level_u           trigger_level_i,
   output logic                              trigger_adc_o,
   output logic                              armed_o
);
   import openadc_pkg::*;

   logic [adc_width-1:0] test_cnt;
   logic [adc_width-1:0] cnt_next;
   logic [adc_width-1:0] sample_q;
   logic                 sample_new;
   logic                 level_hit;

   assign cnt_next = test_cnt + 1'b1;

   // counter leads the captured value, k-th strobe sees k
   always_ff @(posedge clk_usb) begin
      if (reset) begin
         test_cnt   <= '0;
         sample_new <= 1'b0;
      end else begin
         sample_new <= adc_valid_i;
         if (adc_valid_i)
            test_cnt <= cnt_next;
      end
   end

   always_ff @(posedge clk_usb) begin
      if (adc_valid_i)
         sample_q <= data_source_i ? adc_data_i : cnt_next;
   end

   always_comb begin
      if (trigger_level_i.dir.above)
         level_hit = sample_q > trigger_level_i.word;
      else
         level_hit = sample_q < trigger_level_i.word;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         trigger_adc_o <= 1'b0;
         armed_o       <= 1'b0;
      end else begin
         // only fresh samples, and only once per arm
         trigger_adc_o <= armed_o && sample_new && level_hit && !trigger_adc_o;
         if (trigger_adc_o)
            armed_o <= 1'b0;
         else if (arm_pulse_i)
            armed_o <= 1'b1;
      end
   end

   a_one_shot: assert property (
      @(posedge clk_usb) disable iff (reset)
      trigger_adc_o |=> !trigger_adc_o
   ) else $error("level trigger fired on consecutive cycles");

endmodule

// File: rtl/adc_regs.sv
`timescale 1ns/1ps

module adc_regs (
   input  logic                                   clk_usb,
   input  logic                                   reset,
   input  logic [openadc_pkg::reg_addr_width-1:0] reg_address_i,
   input  logic [openadc_pkg::reg_data_width-1:0] reg_datai_i,
   input  logic                                   reg_read_i,
   input  logic                                   reg_write_i,
   input  logic                                   armed_i,
   input  logic [openadc_pkg::freq_width-1:0]     ext_freq_i,
   input  logic                                   ext_changed_i,
   input  logic                                   ext_clk_level_i,
   output logic [openadc_pkg::reg_data_width-1:0] reg_datao_o,
   output logic                                   arm_pulse_o,
   output logic                                   data_source_o,
   output openadc_pkg::adc_level_u                trigger_level_o,
   output openadc_pkg::led_sel_t                  led_select_o,
   output logic                                   monitor_disable_o,
   output logic [openadc_pkg::limit_width-1:0]    ext_limit_o,
   output logic                                   amp_gain_o
);
   import openadc_pkg::*;

   logic [4:1]                ctrl_q;     // bit0 (arm) is not stored
   logic [reg_data_width-1:0] gain_q;
   logic [reg_data_width-1:0] level_lo_q;
   logic [3:0]                level_hi_q;
   logic [reg_data_width-1:0] limit_lo_q;
   logic [reg_data_width-1:0] limit_hi_q;
   logic [8:0]                pwm_acc;
   logic [reg_data_width-1:0] status;
   logic [reg_data_width-1:0] rd_data;
   logic                      arm_write;

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_q     <= '0;
         gain_q     <= '0;
         level_lo_q <= '0;
         level_hi_q <= '0;
         limit_lo_q <= '0;
         limit_hi_q <= '0;
      end else if (reg_write_i) begin
         case (reg_address_i)
            addr_ctrl:     ctrl_q     <= reg_datai_i[4:1];
            addr_gain:     gain_q     <= reg_datai_i;
            addr_level_lo: level_lo_q <= reg_datai_i;
            addr_level_hi: level_hi_q <= reg_datai_i[3:0];
            addr_limit_lo: limit_lo_q <= reg_datai_i;
            addr_limit_hi: limit_hi_q <= reg_datai_i;
            default: ;
         endcase
      end
   end

   assign arm_write = reg_write_i && (reg_address_i == addr_ctrl)
                      && reg_datai_i[ctrl_arm_bit];

   // one cycle only, back to back arm writes collapse
   always_ff @(posedge clk_usb) begin
      if (reset)
         arm_pulse_o <= 1'b0;
      else
         arm_pulse_o <= arm_write && !arm_pulse_o;
   end

   assign data_source_o        = ctrl_q[ctrl_source_bit];
   assign led_select_o         = led_sel_t'(ctrl_q[ctrl_led_lsb +: 2]);
   assign monitor_disable_o    = ctrl_q[ctrl_mondis_bit];
   assign trigger_level_o.word = {level_hi_q, level_lo_q};
   assign ext_limit_o          = {limit_hi_q, limit_lo_q};

   // gain pwm, carry out of the low byte
   always_ff @(posedge clk_usb) begin
      if (reset)
         pwm_acc <= '0;
      else
         pwm_acc <= {1'b0, pwm_acc[7:0]} + {1'b0, gain_q};
   end

   assign amp_gain_o = pwm_acc[8];

   assign status = {5'b00000, ext_clk_level_i, ext_changed_i, armed_i};

   always_comb begin
      rd_data = '0;
      case (reg_address_i)
         addr_ctrl:     rd_data = {3'b000, ctrl_q, 1'b0}; // arm reads back 0
         addr_gain:     rd_data = gain_q;
         addr_level_lo: rd_data = level_lo_q;
         addr_level_hi: rd_data = {4'b0000, level_hi_q};
         addr_freq0:    rd_data = ext_freq_i[7:0];
         addr_freq1:    rd_data = ext_freq_i[15:8];
         addr_freq2:    rd_data = ext_freq_i[23:16];
         addr_freq3:    rd_data = ext_freq_i[31:24];
         addr_limit_lo: rd_data = limit_lo_q;
         addr_limit_hi: rd_data = limit_hi_q;
         addr_status:   rd_data = status;
         default:       rd_data = '0;
      endcase
   end

   // or-bus style, zero when not reading
   assign reg_datao_o = reg_read_i ? rd_data : '0;

   a_arm_single: assert property (
      @(posedge clk_usb) disable iff (reset)
      arm_pulse_o |=> !arm_pulse_o
   ) else $error("arm pulse held for more than one cycle");

endmodule

// File: rtl/openadc_pkg.sv
package openadc_pkg;

   localparam int adc_width      = 12;
   localparam int reg_addr_width = 8;
   localparam int reg_data_width = 8;
   localparam int freq_width     = 32;
   localparam int limit_width    = 16;

   // register map
   localparam logic [reg_addr_width-1:0] addr_ctrl     = 8'h00;
   localparam logic [reg_addr_width-1:0] addr_gain     = 8'h01;
   localparam logic [reg_addr_width-1:0] addr_level_lo = 8'h02;
   localparam logic [reg_addr_width-1:0] addr_level_hi = 8'h03; // low nibble only
   localparam logic [reg_addr_width-1:0] addr_freq0    = 8'h04; // little endian, read only
   localparam logic [reg_addr_width-1:0] addr_freq1    = 8'h05;
   localparam logic [reg_addr_width-1:0] addr_freq2    = 8'h06;
   localparam logic [reg_addr_width-1:0] addr_freq3    = 8'h07;
   localparam logic [reg_addr_width-1:0] addr_limit_lo = 8'h08;
   localparam logic [reg_addr_width-1:0] addr_limit_hi = 8'h09;
   localparam logic [reg_addr_width-1:0] addr_status   = 8'h0C; // read only

   // ctrl bits
   localparam int ctrl_arm_bit    = 0; // write only, self clearing
   localparam int ctrl_source_bit = 1; // 1 = adc, 0 = test counter
   localparam int ctrl_led_lsb    = 2;
   localparam int ctrl_mondis_bit = 4;

   typedef enum logic [1:0] {
      led_status    = 2'd0,
      led_heartbeat = 2'd1
   } led_sel_t; // 2 and 3 reserved, both leds off

   typedef struct packed {
      logic        above;     // 1 = fire above, 0 = fire below
      logic [10:0] magnitude;
   } adc_level_dir_t;

   // threshold word and its direction view
   typedef union packed {
      logic [adc_width-1:0] word;
      adc_level_dir_t       dir;
   } adc_level_u;

endpackage
